// File: design/mipsIsaPkg.sv
package mipsIsaPkg;

  // ==========================================================
  // instruction field and word types
  // ==========================================================

  // data word and byte address
  typedef logic [31:0] wordT;
  // instr[31:26]
  typedef logic [5:0]  opcodeT;
  // instr[5:0], R-type only
  typedef logic [5:0]  functT;
  // rs, rt, rd fields
  typedef logic [4:0]  regIdxT;
  // I-type immediate, instr[15:0]
  typedef logic [15:0] immT;
  // J-type target index, instr[25:0]
  typedef logic [25:0] jumpIdxT;

  // ==========================================================
  // opcodes
  // ==========================================================

  // all R-type share opcode 0, funct picks the op
  localparam opcodeT OpRtype = 6'b000000;
  localparam opcodeT OpJ     = 6'b000010;
  localparam opcodeT OpJal   = 6'b000011;
  localparam opcodeT OpBeq   = 6'b000100;
  localparam opcodeT OpLw    = 6'b100011;
  localparam opcodeT OpSw    = 6'b101011;

  // ==========================================================
  // funct codes
  // ==========================================================

  localparam functT FnJr  = 6'b001000;
  localparam functT FnAdd = 6'b100000;
  localparam functT FnSub = 6'b100010;
  localparam functT FnAnd = 6'b100100;
  localparam functT FnOr  = 6'b100101;
  // signed compare
  localparam functT FnSlt = 6'b101010;

  // link register written by jal
  localparam regIdxT RaReg = 5'd31;

endpackage

// File: design/mipsCorePkg.sv
package mipsCorePkg;

  // ==========================================================
  // ALU operation select
  // ==========================================================

  // none is 0 so an all-zero control word is a no-op
  typedef enum logic [2:0] {
    AluNone = 3'd0,
    AluAdd  = 3'd1,
    AluSub  = 3'd2,
    AluAnd  = 3'd3,
    AluOr   = 3'd4,
    AluSlt  = 3'd5
  } aluOpE;

  // ==========================================================
  // decoded control word, one per instruction
  // ==========================================================

  typedef struct packed {
    // write rd instead of rt
    logic  regDst;
    // ALU operand B from the sign-extended immediate
    logic  aluSrc;
    // write-back from data memory (lw)
    logic  memToReg;
    logic  regWrite;
    // store strobe (sw)
    logic  memWrite;
    // beq, taken when the ALU result is zero
    logic  branch;
    // j and jal
    logic  jump;
    // jal: write PC+4 into ra
    logic  link;
    // jr: next PC from rs
    logic  jumpReg;
    aluOpE aluOp;
  } ctrlT;

endpackage

// File: design/mipsControl.sv
module mipsControl (
  input  mipsIsaPkg::opcodeT opcode,
  input  mipsIsaPkg::functT  funct,
  output mipsCorePkg::ctrlT  ctrl
);

  // ==========================================================
  // main decode and ALU control in one pass
  // ==========================================================

  always_comb begin
    // default is the no-op word, also used for unknown codes
    ctrl = '0;
    case (opcode)
      mipsIsaPkg::OpRtype: begin
        // funct picks the ALU op
        case (funct)
          mipsIsaPkg::FnAdd: ctrl.aluOp = mipsCorePkg::AluAdd;
          mipsIsaPkg::FnSub: ctrl.aluOp = mipsCorePkg::AluSub;
          mipsIsaPkg::FnAnd: ctrl.aluOp = mipsCorePkg::AluAnd;
          mipsIsaPkg::FnOr:  ctrl.aluOp = mipsCorePkg::AluOr;
          mipsIsaPkg::FnSlt: ctrl.aluOp = mipsCorePkg::AluSlt;
          // jr only redirects the PC
          mipsIsaPkg::FnJr:  ctrl.jumpReg = 1'b1;
          default:           ctrl.aluOp = mipsCorePkg::AluNone;
        endcase
        // only real ALU ops write rd
        if (ctrl.aluOp != mipsCorePkg::AluNone) begin
          ctrl.regDst   = 1'b1;
          ctrl.regWrite = 1'b1;
        end
      end
      mipsIsaPkg::OpLw: begin
        // address = base + offset
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = mipsCorePkg::AluAdd;
      end
      mipsIsaPkg::OpSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluOp    = mipsCorePkg::AluAdd;
      end
      mipsIsaPkg::OpBeq: begin
        // rs - rt, zero flag decides
        ctrl.branch = 1'b1;
        ctrl.aluOp  = mipsCorePkg::AluSub;
      end
      mipsIsaPkg::OpJ: begin
        ctrl.jump = 1'b1;
      end
      mipsIsaPkg::OpJal: begin
        // link into ra, no delay slot
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

  // store never retires with a register write
  always_comb begin
    assert (!(ctrl.memWrite && ctrl.regWrite))
      else $error("mipsControl: store decoded with register write");
  end

endmodule

// File: design/mipsRegFile.sv
module mipsRegFile (
  input  logic               clk,
  input  logic               rst,
  input  logic               we,
  input  mipsIsaPkg::regIdxT rdAddrA,
  input  mipsIsaPkg::regIdxT rdAddrB,
  input  mipsIsaPkg::regIdxT wrAddr,
  input  mipsIsaPkg::wordT   wrData,
  output mipsIsaPkg::wordT   rdDataA,
  output mipsIsaPkg::wordT   rdDataB
);

  // 32 x 32 general purpose registers
  mipsIsaPkg::wordT regs [32];

  // ==========================================================
  // write port
  // ==========================================================

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wrAddr != '0)) begin
      // r0 is hardwired, writes to it are dropped
      regs[wrAddr] <= wrData;
    end
  end

  // ==========================================================
  // read ports, combinational
  // ==========================================================

  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

  // r0 stays zero across all edges
  assert property (@(posedge clk) disable iff (!rst) regs[0] == '0)
    else $error("mipsRegFile: register 0 holds a non-zero value");

endmodule

// File: design/mipsAlu.sv
module mipsAlu (
  input  mipsIsaPkg::wordT   opA,
  input  mipsIsaPkg::wordT   opB,
  input  mipsCorePkg::aluOpE aluOp,
  output mipsIsaPkg::wordT   result,
  output logic               zero
);

  // ==========================================================
  // operation select
  // ==========================================================

  always_comb begin
    case (aluOp)
      mipsCorePkg::AluAdd: result = opA + opB;
      // also the beq compare
      mipsCorePkg::AluSub: result = opA - opB;
      mipsCorePkg::AluAnd: result = opA & opB;
      mipsCorePkg::AluOr:  result = opA | opB;
      mipsCorePkg::AluSlt: begin
        // signed compare, result is 1 or 0
        if ($signed(opA) < $signed(opB)) begin
          result = 32'd1;
        end else begin
          result = 32'd0;
        end
      end
      // AluNone and anything else
      default: result = '0;
    endcase
  end

  // zero flag for every op, only beq looks at it
  assign zero = (result == '0);

endmodule

// File: design/mipsPcUnit.sv
module mipsPcUnit (
  input  logic                clk,
  input  logic                rst,
  input  logic                branch,
  input  logic                zero,
  input  logic                jump,
  input  logic                jumpReg,
  input  mipsIsaPkg::wordT    branchOffset,
  input  mipsIsaPkg::jumpIdxT jumpIndex,
  input  mipsIsaPkg::wordT    regTarget,
  output mipsIsaPkg::wordT    pc,
  output mipsIsaPkg::wordT    pcPlus4
);

  mipsIsaPkg::wordT pcNext;

  // sequential successor, also the jal link value
  assign pcPlus4 = pc + 32'd4;

  // ==========================================================
  // next PC, highest priority first
  // ==========================================================

  always_comb begin
    if (jumpReg) begin
      // jr
      pcNext = regTarget;
    end else if (jump) begin
      // j / jal, keep the 256 MB region of PC+4
      pcNext = {pcPlus4[31:28], jumpIndex, 2'b00};
    end else if (branch && zero) begin
      // taken beq, word offset from PC+4
      pcNext = pcPlus4 + {branchOffset[29:0], 2'b00};
    end else begin
      pcNext = pcPlus4;
    end
  end

  // PC register, starts at 0
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

  assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00)
    else $error("mipsPcUnit: unaligned pc %h", pc);

endmodule

// File: design/singleCycleMips.sv
module singleCycleMips #(
  parameter int dmemAddrWidth = 7
) (
  input  logic                     clk,
  input  logic                     rst,
  // instruction memory
  output mipsIsaPkg::wordT         imemAddr,
  input  mipsIsaPkg::wordT         instr,
  // data memory, word addressed
  output logic [dmemAddrWidth-1:0] dmemAddr,
  output mipsIsaPkg::wordT         dmemWrData,
  output logic                     dmemWe,
  input  mipsIsaPkg::wordT         dmemRdData,
  // write-back observation port
  output logic                     wbEn,
  output mipsIsaPkg::regIdxT       wbAddr,
  output mipsIsaPkg::wordT         wbData
);

  // ==========================================================
  // instruction fields
  // ==========================================================

  mipsIsaPkg::opcodeT  opcode;
  mipsIsaPkg::functT   funct;
  mipsIsaPkg::regIdxT  rs;
  mipsIsaPkg::regIdxT  rt;
  mipsIsaPkg::regIdxT  rd;
  mipsIsaPkg::immT     imm;
  mipsIsaPkg::jumpIdxT jumpIndex;
  mipsIsaPkg::wordT    immExt;

  assign opcode    = instr[31:26];
  assign rs        = instr[25:21];
  assign rt        = instr[20:16];
  assign rd        = instr[15:11];
  assign funct     = instr[5:0];
  assign imm       = instr[15:0];
  assign jumpIndex = instr[25:0];
  // sign extension for lw/sw offset and beq
  assign immExt    = {{16{imm[15]}}, imm};

  // ==========================================================
  // datapath
  // ==========================================================

  mipsCorePkg::ctrlT  ctrl;
  mipsIsaPkg::wordT   rsData;
  mipsIsaPkg::wordT   rtData;
  mipsIsaPkg::wordT   aluB;
  mipsIsaPkg::wordT   aluResult;
  logic               aluZero;
  mipsIsaPkg::wordT   pc;
  mipsIsaPkg::wordT   pcPlus4;
  mipsIsaPkg::regIdxT wrAddr;
  mipsIsaPkg::wordT   wrData;

  mipsControl u_control (
    .opcode (opcode),
    .funct  (funct),
    .ctrl   (ctrl)
  );

  // destination: ra for jal, else rd (R-type) or rt (lw)
  assign wrAddr = ctrl.link ? mipsIsaPkg::RaReg : (ctrl.regDst ? rd : rt);
  // link value beats memory beats ALU
  assign wrData = ctrl.link ? pcPlus4 : (ctrl.memToReg ? dmemRdData : aluResult);

  mipsRegFile u_regFile (
    .clk     (clk),
    .rst     (rst),
    .we      (ctrl.regWrite),
    .rdAddrA (rs),
    .rdAddrB (rt),
    .wrAddr  (wrAddr),
    .wrData  (wrData),
    .rdDataA (rsData),
    .rdDataB (rtData)
  );

  // operand B: immediate for lw/sw
  assign aluB = ctrl.aluSrc ? immExt : rtData;

  mipsAlu u_alu (
    .opA    (rsData),
    .opB    (aluB),
    .aluOp  (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  mipsPcUnit u_pcUnit (
    .clk          (clk),
    .rst          (rst),
    .branch       (ctrl.branch),
    .zero         (aluZero),
    .jump         (ctrl.jump),
    .jumpReg      (ctrl.jumpReg),
    .branchOffset (immExt),
    .jumpIndex    (jumpIndex),
    .regTarget    (rsData),
    .pc           (pc),
    .pcPlus4      (pcPlus4)
  );

  // ==========================================================
  // outside ports
  // ==========================================================

  assign imemAddr   = pc;
  // byte address to word index
  assign dmemAddr   = aluResult[dmemAddrWidth+1:2];
  assign dmemWrData = rtData;
  assign dmemWe     = ctrl.memWrite;
  assign wbEn       = ctrl.regWrite;
  assign wbAddr     = wrAddr;
  assign wbData     = wrData;

endmodule

// File: verification/mipsTb.sv
module mipsTb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumCycles = 600;
  // body ends here, words above hold unknown opcodes
  localparam int ProgEnd   = 240;

  logic               clk = 1'b0;
  logic               rst;
  mipsIsaPkg::wordT   imemAddr;
  mipsIsaPkg::wordT   instr;
  logic [6:0]         dmemAddr;
  mipsIsaPkg::wordT   dmemWrData;
  logic               dmemWe;
  mipsIsaPkg::wordT   dmemRdData;
  logic               wbEn;
  mipsIsaPkg::regIdxT wbAddr;
  mipsIsaPkg::wordT   wbData;

  // memories seen by the DUT
  mipsIsaPkg::wordT imem [256];
  mipsIsaPkg::wordT dmem [128];
  // reference model state
  mipsIsaPkg::wordT refRegs [32];
  mipsIsaPkg::wordT refMem [128];
  mipsIsaPkg::wordT refPc;

  int unsigned lcgState = 17875;
  int          errorCount = 0;

  singleCycleMips #(.dmemAddrWidth(7)) u_dut (
    .clk        (clk),
    .rst        (rst),
    .imemAddr   (imemAddr),
    .instr      (instr),
    .dmemAddr   (dmemAddr),
    .dmemWrData (dmemWrData),
    .dmemWe     (dmemWe),
    .dmemRdData (dmemRdData),
    .wbEn       (wbEn),
    .wbAddr     (wbAddr),
    .wbData     (wbData)
  );

  always #4 clk = ~clk;

  // both memories read combinationally
  assign instr      = imem[imemAddr[9:2]];
  assign dmemRdData = dmem[dmemAddr];

  // ==========================================================
  // random program
  // ==========================================================

  function automatic int unsigned nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    // low bits of an LCG cycle fast
    return lcgState >> 8;
  endfunction

  function automatic mipsIsaPkg::regIdxT randReg();
    return 5'(nextRand() % 8);
  endfunction

  function automatic mipsIsaPkg::wordT encR(mipsIsaPkg::functT fn, mipsIsaPkg::regIdxT rs,
                                            mipsIsaPkg::regIdxT rt, mipsIsaPkg::regIdxT rd);
    return {mipsIsaPkg::OpRtype, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic mipsIsaPkg::wordT encI(mipsIsaPkg::opcodeT op, mipsIsaPkg::regIdxT rs,
                                            mipsIsaPkg::regIdxT rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // target given as a word index
  function automatic mipsIsaPkg::wordT encJ(mipsIsaPkg::opcodeT op, int target);
    return {op, 26'(target)};
  endfunction

  task automatic buildProgram();
    int unsigned       kind;
    mipsIsaPkg::functT aluFns [5];
    aluFns = '{mipsIsaPkg::FnAdd, mipsIsaPkg::FnSub, mipsIsaPkg::FnAnd,
               mipsIsaPkg::FnOr, mipsIsaPkg::FnSlt};
    // opcode 0x3f decodes to nothing
    for (int i = 0; i < 256; i++) begin
      imem[i] = {6'h3f, 26'(i * 7919)};
    end
    // prologue, clear r1..r7 on every pass
    for (int r = 1; r < 8; r++) begin
      imem[r - 1] = encR(mipsIsaPkg::FnSub, 5'(r), 5'(r), 5'(r));
    end
    // sets ra for later jr, lands on the next word
    imem[7] = encJ(mipsIsaPkg::OpJal, 8);
    for (int i = 8; i < ProgEnd; i++) begin
      kind = nextRand() % 32;
      case (kind) inside
        [0:15]:  imem[i] = encR(aluFns[nextRand() % 5], randReg(), randReg(), randReg());
        [16:20]: imem[i] = encI(mipsIsaPkg::OpLw, 5'd0, randReg(), 16'((nextRand() % 128) * 4));
        [21:24]: imem[i] = encI(mipsIsaPkg::OpSw, 5'd0, randReg(), 16'((nextRand() % 128) * 4));
        // forward branches only
        [25:27]: imem[i] = encI(mipsIsaPkg::OpBeq, randReg(), randReg(), 16'(1 + nextRand() % 8));
        28:      imem[i] = encJ(mipsIsaPkg::OpJ, i + 2 + int'(nextRand() % 13));
        29:      imem[i] = encJ(mipsIsaPkg::OpJal, i + 2 + int'(nextRand() % 13));
        30:      imem[i] = encR(mipsIsaPkg::FnJr, 5'd31, 5'd0, 5'd0);
        // 31 keeps the unknown opcode
        default: ;
      endcase
    end
    // wrap to the prologue
    imem[255] = encJ(mipsIsaPkg::OpJ, 0);
  endtask

  // ==========================================================
  // reference model and checks
  // ==========================================================

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // one instruction of the ISA model against the DUT outputs
  task automatic retireAndCheck(output logic lost);
    mipsIsaPkg::wordT   ins;
    mipsIsaPkg::wordT   rsVal;
    mipsIsaPkg::wordT   rtVal;
    mipsIsaPkg::wordT   offset;
    mipsIsaPkg::wordT   nextPc;
    mipsIsaPkg::wordT   expData;
    mipsIsaPkg::regIdxT expAddr;
    logic               expWe;
    logic               expStore;
    logic [6:0]         memIdx;
    lost = 1'b0;
    if (refPc >= 32'd1024) begin
      errorCount++;
      $display("program counter left instruction memory at %0t, pc %h", $time, refPc);
      lost = 1'b1;
      return;
    end
    ins      = imem[refPc[9:2]];
    rsVal    = refRegs[ins[25:21]];
    rtVal    = refRegs[ins[20:16]];
    offset   = {{16{ins[15]}}, ins[15:0]};
    memIdx   = 7'((rsVal + offset) >> 2);
    nextPc   = refPc + 32'd4;
    expWe    = 1'b0;
    expStore = 1'b0;
    expAddr  = '0;
    expData  = '0;
    case (ins[31:26])
      mipsIsaPkg::OpRtype: begin
        expWe   = 1'b1;
        expAddr = ins[15:11];
        case (ins[5:0])
          mipsIsaPkg::FnAdd: expData = rsVal + rtVal;
          mipsIsaPkg::FnSub: expData = rsVal - rtVal;
          mipsIsaPkg::FnAnd: expData = rsVal & rtVal;
          mipsIsaPkg::FnOr:  expData = rsVal | rtVal;
          mipsIsaPkg::FnSlt: expData = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
          mipsIsaPkg::FnJr: begin
            expWe  = 1'b0;
            nextPc = rsVal;
          end
          default: expWe = 1'b0;
        endcase
      end
      mipsIsaPkg::OpLw: begin
        expWe   = 1'b1;
        expAddr = ins[20:16];
        expData = refMem[memIdx];
      end
      mipsIsaPkg::OpSw:  expStore = 1'b1;
      mipsIsaPkg::OpBeq: nextPc = (rsVal == rtVal) ? nextPc + (offset << 2) : nextPc;
      mipsIsaPkg::OpJ:   nextPc = {nextPc[31:28], ins[25:0], 2'b00};
      mipsIsaPkg::OpJal: begin
        // link is the return address, no delay slot
        expWe   = 1'b1;
        expAddr = mipsIsaPkg::RaReg;
        expData = nextPc;
        nextPc  = {nextPc[31:28], ins[25:0], 2'b00};
      end
      default: ;
    endcase
    checkValue("imemAddr", imemAddr, refPc);
    checkValue("wbEn", 32'(wbEn), 32'(expWe));
    checkValue("dmemWe", 32'(dmemWe), 32'(expStore));
    if (expWe) begin
      checkValue("wbAddr", 32'(wbAddr), 32'(expAddr));
      checkValue("wbData", wbData, expData);
    end
    if (expStore) begin
      checkValue("dmemAddr", 32'(dmemAddr), 32'(memIdx));
      checkValue("dmemWrData", dmemWrData, rtVal);
      refMem[memIdx] = rtVal;
    end
    // store commits before the next fetch
    if (dmemWe) begin
      dmem[dmemAddr] = dmemWrData;
    end
    if (expWe && expAddr != 5'd0) begin
      refRegs[expAddr] = expData;
    end
    refPc = nextPc;
  endtask

  // ==========================================================
  // main sequence
  // ==========================================================

  initial begin
    logic lost;
    int   cycle;
    rst = 1'b0;
    for (int i = 0; i < 128; i++) begin
      dmem[i]   = 32'(i) * 32'h9e3779b1 + 32'h0badf00d;
      refMem[i] = dmem[i];
    end
    for (int r = 0; r < 32; r++) begin
      refRegs[r] = '0;
    end
    buildProgram();
    refPc = '0;
    lost  = 1'b0;
    cycle = 0;
    repeat (2) @(posedge clk);
    #1 rst = 1'b1;
    // outputs settle by the falling edge
    while (cycle < NumCycles && !lost) begin
      @(negedge clk);
      retireAndCheck(lost);
      cycle++;
    end
    $display("run done after %0d cycles with %0d errors", cycle, errorCount);
    if (errorCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: singleCycleMips.f
design/mipsIsaPkg.sv
design/mipsCorePkg.sv
design/mipsControl.sv
design/mipsRegFile.sv
design/mipsAlu.sv
design/mipsPcUnit.sv
design/singleCycleMips.sv
verification/mipsTb.sv

// File: Makefile
TOP = mipsTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module $(TOP) -Mdir obj_dir -o Vmips -f singleCycleMips.f

run: compile
	./obj_dir/Vmips > run.log 2>&1 || true
	cat run.log
	@if grep -q "STATUS: FAIL" run.log || ! grep -q "STATUS: PASS" run.log; then \
	  echo "simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir run.log
